// ==== all.f ====
src/dispatch_pkg.sv
src/dispatch_queue.sv
src/issue_select.sv
src/exec_unit.sv
src/wb_arbiter.sv
src/dispatch_top.sv
dv/dispatch_tb.sv

// ==== dv/golden_dispatch.hex ====
// Columns: fu pdest src0 src1 src0_ready src1_ready opa opb expected ext_wake
// fu 0 adder, 1 multiplier; ext_wake bit 0 wakes src0, bit 1 wakes src1 via ext_wb_i
// Pair 0, head waits on an external wakeup so the queue fills
0 01 18 00 0 1 0012 0034 0046 1
1 02 01 00 0 1 0003 0005 000f 0
// Pair 1, carry wrap and a wakeup from the previous pair
0 03 00 00 1 1 1234 1111 2345 0
0 04 03 02 0 0 ffff 0002 0001 0
// Pair 2, product overflow and an external second source
1 05 00 00 1 1 0100 0100 0000 0
1 06 05 19 0 0 00ff 00ff fe01 2
// Pair 3
0 07 06 00 0 1 7fff 0001 8000 0
1 08 1a 1b 0 0 0007 0009 003f 3
// Pair 4
0 09 08 07 0 0 0a0a 0505 0f0f 0
0 0a 00 00 1 1 8000 8000 0000 0
// Pair 5
1 0b 00 00 1 1 1234 0010 2340 0
1 0c 0b 09 0 0 0002 8001 0002 0
// Pair 6
0 0d 1c 00 0 1 0001 0001 0002 1
0 0e 0d 0c 0 0 abcd 1111 bcde 0
// Pair 7
1 0f 00 00 1 1 0011 0011 0121 0
0 10 0f 1d 0 0 0f00 00f0 0ff0 2
// Pair 8
1 11 10 0f 0 0 0003 0004 000c 0
0 12 11 1e 0 0 0100 0200 0300 2
// Pair 9, last ops chain through both units
1 13 12 1f 0 0 fffe 0002 fffc 2
0 14 13 11 0 0 5555 aaaa ffff 0

// ==== dv/dispatch_tb.sv ====
// Testbench for the dispatch back end
// Drives micro-op pairs from the golden file into the queue and checks each
// writeback for data, per-unit order, source wakeup timing and uniqueness
`timescale 1ns/1ps

module dispatch_tb;
	import dispatch_pkg::*;

	localparam int NUM_OPS = 20;
	// Tokens per golden line
	localparam int FIELDS = 10;
	localparam int NUM_PAIRS = NUM_OPS / DECODE_WIDTH;
	localparam int CYCLE_LIMIT = NUM_OPS * 40 + 100;

	logic clk;
	logic rst_n;
	logic [DECODE_WIDTH-1:0] write_valid_i;
	dq_entry_t [DECODE_WIDTH-1:0] write_data_i;
	logic write_ready_o;
	logic ext_wb_i;
	phy_tag_t ext_pdest_i;
	logic wb_valid_o;
	phy_tag_t wb_pdest_o;
	logic [DATA_W-1:0] wb_data_o;

	// Golden ops, unpacked per field
	logic [15:0] golden [0:NUM_OPS*FIELDS-1];
	fu_sel_t op_fu [NUM_OPS];
	phy_tag_t op_pdest [NUM_OPS];
	phy_tag_t op_src0 [NUM_OPS];
	phy_tag_t op_src1 [NUM_OPS];
	logic op_rdy0 [NUM_OPS];
	logic op_rdy1 [NUM_OPS];
	logic [DATA_W-1:0] op_a [NUM_OPS];
	logic [DATA_W-1:0] op_b [NUM_OPS];
	logic [DATA_W-1:0] op_exp [NUM_OPS];
	logic [1:0] op_ext [NUM_OPS];

	// Scoreboard indexed by pdest, plus broadcast log per tag
	int tag_owner [PHY_REG_NUM];
	bit op_done [NUM_OPS];
	bit tag_seen [PHY_REG_NUM];
	int tag_cycle [PHY_REG_NUM];
	// Expected writeback order of each unit
	int alu_order [$];
	int mul_order [$];
	// Pending external wakeups
	phy_tag_t ext_tag_q [$];
	int ext_due_q [$];

	integer seed;
	int cycle;
	int done_cnt;
	int mismatches;
	int other_errors;
	int pair_idx;
	bit run;
	bit ready_seen;
	bit full_seen;

	dispatch_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.write_valid_i(write_valid_i),
		.write_data_i(write_data_i),
		.write_ready_o(write_ready_o),
		.ext_wb_i(ext_wb_i),
		.ext_pdest_i(ext_pdest_i),
		.wb_valid_o(wb_valid_o),
		.wb_pdest_o(wb_pdest_o),
		.wb_data_o(wb_data_o)
	);

	always #10 clk = ~clk;

	// ==================================================
	// Compare tasks and error log
	// ==================================================
	task automatic check_tag(input string name, input phy_tag_t got, input phy_tag_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		other_errors++;
		$display("error: %s", msg);
	endtask

	// ==================================================
	// Golden data
	// ==================================================
	task automatic load_golden();
		int b;
		$readmemh("dv/golden_dispatch.hex", golden);
		for (int t = 0; t < PHY_REG_NUM; t++) begin
			tag_owner[t] = -1;
		end
		for (int i = 0; i < NUM_OPS; i++) begin
			b = i * FIELDS;
			if ($isunknown(golden[b+FIELDS-1])) begin
				note_failure($sformatf("golden file has no complete line for op %0d", i));
			end
			op_fu[i] = fu_sel_t'(golden[b][0]);
			op_pdest[i] = phy_tag_t'(golden[b+1]);
			op_src0[i] = phy_tag_t'(golden[b+2]);
			op_src1[i] = phy_tag_t'(golden[b+3]);
			op_rdy0[i] = golden[b+4][0];
			op_rdy1[i] = golden[b+5][0];
			op_a[i] = golden[b+6];
			op_b[i] = golden[b+7];
			op_exp[i] = golden[b+8];
			op_ext[i] = golden[b+9][1:0];
			if (tag_owner[op_pdest[i]] >= 0) begin
				note_failure($sformatf("golden file reuses pdest 0x%h", op_pdest[i]));
			end
			tag_owner[op_pdest[i]] = i;
			// Same unit retires in program order
			if (op_fu[i] == FU_ALU) begin
				alu_order.push_back(i);
			end else begin
				mul_order.push_back(i);
			end
		end
	endtask

	function automatic dq_entry_t make_entry(input int idx);
		dq_entry_t e;
		e.fu = op_fu[idx];
		e.pdest = op_pdest[idx];
		e.src0 = op_src0[idx];
		e.src1 = op_src1[idx];
		e.src0_ready = op_rdy0[idx];
		e.src1_ready = op_rdy1[idx];
		e.opa = op_a[idx];
		e.opb = op_b[idx];
		return e;
	endfunction

	// External wakeup a random 4 to 19 cycles after the op is in the queue
	task automatic schedule_wakeups(input int idx);
		if (op_ext[idx][0]) begin
			ext_tag_q.push_back(op_src0[idx]);
			ext_due_q.push_back(cycle + 4 + int'($unsigned($random(seed)) % 16));
		end
		if (op_ext[idx][1]) begin
			ext_tag_q.push_back(op_src1[idx]);
			ext_due_q.push_back(cycle + 4 + int'($unsigned($random(seed)) % 16));
		end
	endtask

	// ==================================================
	// Writeback scoreboard
	// ==================================================
	task automatic confirm_wakeup(input int idx, input phy_tag_t src);
		if (!tag_seen[src] || tag_cycle[src] >= cycle) begin
			note_failure($sformatf("result 0x%h came before source 0x%h was broadcast",
				op_pdest[idx], src));
		end
	endtask

	task automatic handle_writeback();
		int idx;
		int head;
		if ($isunknown(wb_pdest_o)) begin
			note_failure("wb_pdest_o is unknown while wb_valid_o is high");
			return;
		end
		idx = tag_owner[wb_pdest_o];
		if (idx < 0) begin
			note_failure($sformatf("writeback to tag 0x%h, which no golden op produces",
				wb_pdest_o));
			return;
		end
		if (op_done[idx]) begin
			note_failure($sformatf("tag 0x%h written back more than once", wb_pdest_o));
			return;
		end
		// Oldest outstanding op of that unit must come first
		if (op_fu[idx] == FU_ALU) begin
			head = alu_order.pop_front();
		end else begin
			head = mul_order.pop_front();
		end
		check_tag("wb_pdest_o", wb_pdest_o, op_pdest[head]);
		check_data("wb_data_o", wb_data_o, op_exp[idx]);
		if (!op_rdy0[idx]) begin
			confirm_wakeup(idx, op_src0[idx]);
		end
		if (!op_rdy1[idx]) begin
			confirm_wakeup(idx, op_src1[idx]);
		end
		op_done[idx] = 1'b1;
		done_cnt++;
	endtask

	// ==================================================
	// Stimulus, rising edge
	// ==================================================
	always @(posedge clk) begin
		int found;
		if (run) begin
			cycle = cycle + 1;
			// At most one external wakeup per cycle
			found = -1;
			for (int q = 0; q < ext_tag_q.size(); q++) begin
				if (found < 0 && ext_due_q[q] <= cycle) begin
					found = q;
				end
			end
			if (found >= 0) begin
				ext_wb_i <= 1'b1;
				ext_pdest_i <= ext_tag_q[found];
				ext_tag_q.delete(found);
				ext_due_q.delete(found);
			end else begin
				ext_wb_i <= 1'b0;
			end
			// Pair taken at this edge when ready was high before it
			if (write_valid_i != '0 && ready_seen) begin
				for (int k = 0; k < DECODE_WIDTH; k++) begin
					schedule_wakeups(pair_idx * DECODE_WIDTH + k);
				end
				pair_idx = pair_idx + 1;
			end
			// Held pair is simply driven again
			if (pair_idx < NUM_PAIRS) begin
				for (int k = 0; k < DECODE_WIDTH; k++) begin
					write_valid_i[k] <= 1'b1;
					write_data_i[k] <= make_entry(pair_idx * DECODE_WIDTH + k);
				end
			end else begin
				write_valid_i <= '0;
			end
		end
	end

	// Outputs sampled mid-cycle
	always @(negedge clk) begin
		ready_seen = write_ready_o;
		if (run) begin
			if (!write_ready_o) begin
				full_seen = 1'b1;
			end
			if (wb_valid_o) begin
				handle_writeback();
				tag_seen[wb_pdest_o] = 1'b1;
				tag_cycle[wb_pdest_o] = cycle;
			end
			if (ext_wb_i) begin
				tag_seen[ext_pdest_i] = 1'b1;
				tag_cycle[ext_pdest_i] = cycle;
			end
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int waited;
		clk = 1'b0;
		rst_n = 1'b0;
		write_valid_i = '0;
		write_data_i = '0;
		ext_wb_i = 1'b0;
		ext_pdest_i = '0;
		seed = 32'hd266f343;
		cycle = 0;
		done_cnt = 0;
		mismatches = 0;
		other_errors = 0;
		pair_idx = 0;
		run = 1'b0;
		ready_seen = 1'b0;
		full_seen = 1'b0;
		load_golden();

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		expect_flag("wb_valid_o", wb_valid_o, 1'b0);
		expect_flag("write_ready_o", write_ready_o, 1'b1);
		run <= 1'b1;

		// Wait for every writeback, bounded by the cycle limit
		waited = 0;
		while (done_cnt < NUM_OPS && waited < CYCLE_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		// Extra cycles catch a late duplicate
		repeat (10) @(posedge clk);
		if (done_cnt < NUM_OPS) begin
			note_failure($sformatf("timeout after %0d cycles with %0d of %0d ops written back",
				waited, done_cnt, NUM_OPS));
		end
		if (!full_seen) begin
			note_failure("write_ready_o never dropped while the burst filled the queue");
		end
		$display("Error count: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== src/dispatch_top.sv ====
// Dispatch back end top level
// Queue feeds in-order issue into an adder and a multiplier
// Results share one writeback bus that also wakes the queue
`timescale 1ns/1ps

module dispatch_top #(
	parameter int QUEUE_DEPTH = 8,
	parameter int ALU_LATENCY = 1,
	parameter int MUL_LATENCY = 3
) (
	input  logic clk,
	input  logic rst_n,
	// Decode side
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0] write_valid_i,
	input  dispatch_pkg::dq_entry_t [dispatch_pkg::DECODE_WIDTH-1:0] write_data_i,
	output logic write_ready_o,
	// External wakeup strobe
	input  logic ext_wb_i,
	input  dispatch_pkg::phy_tag_t ext_pdest_i,
	// Writeback bus
	output logic wb_valid_o,
	output dispatch_pkg::phy_tag_t wb_pdest_o,
	output logic [dispatch_pkg::DATA_W-1:0] wb_data_o
);
	import dispatch_pkg::*;

	// ==================================================
	// Queue to issue
	// ==================================================
	logic [DISPATCH_WIDTH-1:0] read_valid;
	dq_entry_t [DISPATCH_WIDTH-1:0] read_data;
	logic [DISPATCH_WIDTH-1:0] read_ready;

	// Issue to units
	logic alu_accept;
	logic alu_start;
	logic [DATA_W-1:0] alu_opa;
	logic [DATA_W-1:0] alu_opb;
	phy_tag_t alu_pdest;
	logic mul_accept;
	logic mul_start;
	logic [DATA_W-1:0] mul_opa;
	logic [DATA_W-1:0] mul_opb;
	phy_tag_t mul_pdest;

	// Units to arbiter, index 0 is the adder
	logic [1:0] res_valid;
	phy_tag_t [1:0] res_pdest;
	logic [1:0][DATA_W-1:0] res_data;
	logic [1:0] res_grant;

	// Wakeup source 0 is our bus, source 1 the external port
	dispatch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.write_valid_i(write_valid_i),
		.write_data_i(write_data_i),
		.write_ready_o(write_ready_o),
		.read_valid_o(read_valid),
		.read_data_o(read_data),
		.read_ready_i(read_ready),
		.wb_valid_i({ext_wb_i, wb_valid_o}),
		.wb_pdest_i({ext_pdest_i, wb_pdest_o})
	);

	issue_select u_issue (
		.read_valid_i(read_valid),
		.read_data_i(read_data),
		.read_ready_o(read_ready),
		.alu_accept_i(alu_accept),
		.mul_accept_i(mul_accept),
		.alu_start_o(alu_start),
		.mul_start_o(mul_start),
		.alu_opa_o(alu_opa),
		.alu_opb_o(alu_opb),
		.alu_pdest_o(alu_pdest),
		.mul_opa_o(mul_opa),
		.mul_opb_o(mul_opb),
		.mul_pdest_o(mul_pdest)
	);

	// ==================================================
	// Execution units
	// ==================================================
	exec_unit #(
		.LATENCY(ALU_LATENCY),
		.OP(FU_ALU)
	) u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(alu_start),
		.opa_i(alu_opa),
		.opb_i(alu_opb),
		.pdest_i(alu_pdest),
		.accept_o(alu_accept),
		.result_valid_o(res_valid[0]),
		.result_pdest_o(res_pdest[0]),
		.result_data_o(res_data[0]),
		.grant_i(res_grant[0])
	);

	exec_unit #(
		.LATENCY(MUL_LATENCY),
		.OP(FU_MUL)
	) u_mul (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(mul_start),
		.opa_i(mul_opa),
		.opb_i(mul_opb),
		.pdest_i(mul_pdest),
		.accept_o(mul_accept),
		.result_valid_o(res_valid[1]),
		.result_pdest_o(res_pdest[1]),
		.result_data_o(res_data[1]),
		.grant_i(res_grant[1])
	);

	wb_arbiter #(
		.NUM_UNITS(2)
	) u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.req_i(res_valid),
		.pdest_i(res_pdest),
		.data_i(res_data),
		.grant_o(res_grant),
		.wb_valid_o(wb_valid_o),
		.wb_pdest_o(wb_pdest_o),
		.wb_data_o(wb_data_o)
	);

endmodule

// ==== src/wb_arbiter.sv ====
// Round-robin owner of the shared writeback bus
// One unit is granted per cycle, its result is registered onto the bus
// The bus is a single-cycle strobe with no back-pressure
`timescale 1ns/1ps

module wb_arbiter #(
	parameter int NUM_UNITS = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [NUM_UNITS-1:0] req_i,
	input  dispatch_pkg::phy_tag_t [NUM_UNITS-1:0] pdest_i,
	input  logic [NUM_UNITS-1:0][dispatch_pkg::DATA_W-1:0] data_i,
	output logic [NUM_UNITS-1:0] grant_o,
	output logic wb_valid_o,
	output dispatch_pkg::phy_tag_t wb_pdest_o,
	output logic [dispatch_pkg::DATA_W-1:0] wb_data_o
);
	import dispatch_pkg::*;

	localparam int IDX_W = $clog2(NUM_UNITS);

	// Unit with highest priority this cycle
	logic [IDX_W-1:0] prio_q;
	logic [IDX_W-1:0] sel;
	logic found;

	// Search from the pointer, wrapping around
	always_comb begin
		int idx;
		grant_o = '0;
		sel = '0;
		found = 1'b0;
		for (int k = 0; k < NUM_UNITS; k++) begin
			idx = (int'(prio_q) + k) % NUM_UNITS;
			if (!found && req_i[idx]) begin
				grant_o[idx] = 1'b1;
				sel = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	// Pointer moves past the winner, reset favours the adder
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_q <= '0;
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= found;
			if (found) begin
				prio_q <= IDX_W'((int'(sel) + 1) % NUM_UNITS);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			wb_pdest_o <= pdest_i[sel];
			wb_data_o <= data_i[sel];
		end
	end

endmodule

// ==== src/exec_unit.sv ====
// Pipelined execution unit, adder or multiplier by OP
// LATENCY pipe stages feed a one-entry result buffer
// The whole pipe stalls while the buffer waits for a grant
`timescale 1ns/1ps

module exec_unit #(
	parameter int LATENCY = 1,
	parameter dispatch_pkg::fu_sel_t OP = dispatch_pkg::FU_ALU
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start_i,
	input  logic [dispatch_pkg::DATA_W-1:0] opa_i,
	input  logic [dispatch_pkg::DATA_W-1:0] opb_i,
	input  dispatch_pkg::phy_tag_t pdest_i,
	output logic accept_o,
	output logic result_valid_o,
	output dispatch_pkg::phy_tag_t result_pdest_o,
	output logic [dispatch_pkg::DATA_W-1:0] result_data_o,
	input  logic grant_i
);
	import dispatch_pkg::*;

	logic [DATA_W-1:0] op_result;
	// Pipe stages, index 0 takes the start
	logic [LATENCY-1:0] stage_valid;
	phy_tag_t [LATENCY-1:0] stage_pdest;
	logic [LATENCY-1:0][DATA_W-1:0] stage_data;
	// Result buffer
	logic buf_valid;
	phy_tag_t buf_pdest;
	logic [DATA_W-1:0] buf_data;
	logic hold;

	// Low half of the product for the multiplier
	always_comb begin
		if (OP == FU_MUL) begin
			op_result = opa_i * opb_i;
		end else begin
			op_result = opa_i + opb_i;
		end
	end

	// Buffer occupied and not leaving this cycle
	assign hold = buf_valid && !grant_i;
	assign accept_o = !hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= '0;
			buf_valid <= 1'b0;
		end else if (!hold) begin
			stage_valid[0] <= start_i;
			for (int s = 1; s < LATENCY; s++) begin
				stage_valid[s] <= stage_valid[s-1];
			end
			buf_valid <= stage_valid[LATENCY-1];
		end
	end

	// Payload follows the valid bits
	always_ff @(posedge clk) begin
		if (!hold) begin
			stage_pdest[0] <= pdest_i;
			stage_data[0] <= op_result;
			for (int s = 1; s < LATENCY; s++) begin
				stage_pdest[s] <= stage_pdest[s-1];
				stage_data[s] <= stage_data[s-1];
			end
			buf_pdest <= stage_pdest[LATENCY-1];
			buf_data <= stage_data[LATENCY-1];
		end
	end

	assign result_valid_o = buf_valid;
	assign result_pdest_o = buf_pdest;
	assign result_data_o = buf_data;

endmodule

// ==== src/issue_select.sv ====
// In-order issue from the dispatch queue head
// Picks a prefix of ready head entries and starts their units
// Purely combinational, the issue happens in the read cycle
`timescale 1ns/1ps

module issue_select (
	// Queue head
	input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0] read_valid_i,
	input  dispatch_pkg::dq_entry_t [dispatch_pkg::DISPATCH_WIDTH-1:0] read_data_i,
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0] read_ready_o,
	// Unit availability
	input  logic alu_accept_i,
	input  logic mul_accept_i,
	// Adder start
	output logic alu_start_o,
	output logic [dispatch_pkg::DATA_W-1:0] alu_opa_o,
	output logic [dispatch_pkg::DATA_W-1:0] alu_opb_o,
	output dispatch_pkg::phy_tag_t alu_pdest_o,
	// Multiplier start
	output logic mul_start_o,
	output logic [dispatch_pkg::DATA_W-1:0] mul_opa_o,
	output logic [dispatch_pkg::DATA_W-1:0] mul_opb_o,
	output dispatch_pkg::phy_tag_t mul_pdest_o
);
	import dispatch_pkg::*;

	// ==================================================
	// Head walk
	// ==================================================
	always_comb begin
		dq_entry_t entry;
		logic stop;
		logic unit_free;
		read_ready_o = '0;
		alu_start_o = 1'b0;
		alu_opa_o = '0;
		alu_opb_o = '0;
		alu_pdest_o = '0;
		mul_start_o = 1'b0;
		mul_opa_o = '0;
		mul_opb_o = '0;
		mul_pdest_o = '0;
		stop = 1'b0;
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			entry = read_data_i[i];
			// Unit must accept and not be claimed by an older entry
			if (entry.fu == FU_ALU) begin
				unit_free = alu_accept_i && !alu_start_o;
			end else begin
				unit_free = mul_accept_i && !mul_start_o;
			end
			if (stop || !read_valid_i[i] || !entry.src0_ready || !entry.src1_ready
				|| !unit_free) begin
				// Younger entries wait behind this one
				stop = 1'b1;
			end else begin
				read_ready_o[i] = 1'b1;
				if (entry.fu == FU_ALU) begin
					alu_start_o = 1'b1;
					alu_opa_o = entry.opa;
					alu_opb_o = entry.opb;
					alu_pdest_o = entry.pdest;
				end else begin
					mul_start_o = 1'b1;
					mul_opa_o = entry.opa;
					mul_opb_o = entry.opb;
					mul_pdest_o = entry.pdest;
				end
			end
		end
	end

endmodule

// ==== src/dispatch_queue.sv ====
// Circular dispatch queue with two write and two read ports
// Source readiness is tracked per entry and set by tag wakeups
// Writes need contiguous valid lanes, reads are a prefix from the head
`timescale 1ns/1ps

module dispatch_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic clk,
	input  logic rst_n,
	// Decode side
	input  logic [dispatch_pkg::DECODE_WIDTH-1:0] write_valid_i,
	input  dispatch_pkg::dq_entry_t [dispatch_pkg::DECODE_WIDTH-1:0] write_data_i,
	output logic write_ready_o,
	// Issue side
	output logic [dispatch_pkg::DISPATCH_WIDTH-1:0] read_valid_o,
	output dispatch_pkg::dq_entry_t [dispatch_pkg::DISPATCH_WIDTH-1:0] read_data_o,
	input  logic [dispatch_pkg::DISPATCH_WIDTH-1:0] read_ready_i,
	// Wakeup broadcasts
	input  logic [dispatch_pkg::WB_WIDTH-1:0] wb_valid_i,
	input  dispatch_pkg::phy_tag_t [dispatch_pkg::WB_WIDTH-1:0] wb_pdest_i
);
	import dispatch_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage, validity comes from head and count
	dq_entry_t [QUEUE_DEPTH-1:0] queue_q;
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] count_q;

	logic [DECODE_WIDTH-1:0] write_fire;
	logic [DISPATCH_WIDTH-1:0] read_fire;
	logic [CNT_W-1:0] write_cnt;
	logic [CNT_W-1:0] read_cnt;
	// Incoming entries with same-cycle wakeups merged
	dq_entry_t [DECODE_WIDTH-1:0] write_entry;

	// True when any valid broadcast carries this tag
	function automatic logic tag_woken(
		input phy_tag_t tag,
		input logic [WB_WIDTH-1:0] vld,
		input phy_tag_t [WB_WIDTH-1:0] tags
	);
		logic hit;
		hit = 1'b0;
		for (int j = 0; j < WB_WIDTH; j++) begin
			if (vld[j] && tags[j] == tag) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// ==================================================
	// Handshake and port data
	// ==================================================
	// Room for a full decode group
	assign write_ready_o = count_q <= CNT_W'(QUEUE_DEPTH - DECODE_WIDTH);
	assign write_fire = write_ready_o ? write_valid_i : '0;

	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			read_valid_o[i] = count_q > CNT_W'(i);
			read_data_o[i] = queue_q[head_q + PTR_W'(i)];
		end
	end

	assign read_fire = read_valid_o & read_ready_i;

	// Lane counts
	always_comb begin
		write_cnt = '0;
		read_cnt = '0;
		for (int k = 0; k < DECODE_WIDTH; k++) begin
			write_cnt = write_cnt + CNT_W'(write_fire[k]);
		end
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			read_cnt = read_cnt + CNT_W'(read_fire[i]);
		end
	end

	// A source broadcast while the op is written lands ready
	always_comb begin
		for (int k = 0; k < DECODE_WIDTH; k++) begin
			write_entry[k] = write_data_i[k];
			write_entry[k].src0_ready = write_data_i[k].src0_ready
				| tag_woken(write_data_i[k].src0, wb_valid_i, wb_pdest_i);
			write_entry[k].src1_ready = write_data_i[k].src1_ready
				| tag_woken(write_data_i[k].src1, wb_valid_i, wb_pdest_i);
		end
	end

	// ==================================================
	// Pointers and occupancy
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			head_q <= head_q + PTR_W'(read_cnt);
			tail_q <= tail_q + PTR_W'(write_cnt);
			count_q <= count_q + write_cnt - read_cnt;
		end
	end

	// Entry array
	always_ff @(posedge clk) begin
		// Resident wakeup, free slots too since they are rewritten before use
		for (int e = 0; e < QUEUE_DEPTH; e++) begin
			if (tag_woken(queue_q[e].src0, wb_valid_i, wb_pdest_i)) begin
				queue_q[e].src0_ready <= 1'b1;
			end
			if (tag_woken(queue_q[e].src1, wb_valid_i, wb_pdest_i)) begin
				queue_q[e].src1_ready <= 1'b1;
			end
		end
		// New ops go to free slots from the tail
		for (int k = 0; k < DECODE_WIDTH; k++) begin
			if (write_fire[k]) begin
				queue_q[tail_q + PTR_W'(k)] <= write_entry[k];
			end
		end
	end

endmodule

// ==== src/dispatch_pkg.sv ====
// Shared definitions for the dispatch back end
// Widths, physical tag type, unit select and the queue entry layout
// Every RTL module and the testbench import from here
package dispatch_pkg;

	// ==================================================
	// Widths
	// ==================================================
	// Micro-ops written into the queue per cycle
	parameter int DECODE_WIDTH = 2;
	// Queue read ports seen by issue
	parameter int DISPATCH_WIDTH = 2;
	parameter int PHY_REG_NUM = 32;
	parameter int TAG_W = $clog2(PHY_REG_NUM);
	// Operand and result width
	parameter int DATA_W = 16;
	// Wakeup sources, 0 is the writeback bus and 1 the external port
	parameter int WB_WIDTH = 2;

	// ==================================================
	// Types
	// ==================================================
	typedef logic [TAG_W-1:0] phy_tag_t;

	// Target execution unit of a micro-op
	typedef enum logic {
		FU_ALU = 1'b0,
		FU_MUL = 1'b1
	} fu_sel_t;

	// One dispatch queue slot
	typedef struct packed {
		fu_sel_t fu;
		phy_tag_t pdest;
		phy_tag_t src0;
		phy_tag_t src1;
		// Set once the source tag has been broadcast
		logic src0_ready;
		logic src1_ready;
		// Operand values carried with the op
		logic [DATA_W-1:0] opa;
		logic [DATA_W-1:0] opb;
	} dq_entry_t;

endpackage
